// ==== source/msx_upload_pkg.sv ====
package msx_upload_pkg;

   // Kind of a configuration table entry
   typedef enum logic [2:0] {
      config_none,
      config_ram,
      config_bios,
      config_fdc,
      config_kbd_layout
   } config_typ_e;

   // Slot and subslot kind
   typedef enum logic [2:0] {
      slot_typ_empty,
      slot_typ_rom,
      slot_typ_ram,
      slot_typ_msx2_ram,
      slot_typ_mapper
   } slot_typ_e;

   typedef enum logic [1:0] {
      block_typ_ram,
      block_typ_rom,
      block_typ_fdc
   } block_typ_e;

   typedef struct packed {
      config_typ_e typ;
      logic [1:0]  slot;
      logic [1:0]  sub_slot;
      logic [1:0]  start_block;     // First 16 KB page
      logic [3:0]  block_id;
      logic [7:0]  block_count;     // In 16 KB blocks
      logic [27:0] store_address;   // Image location in DDR3
   } config_t;

   typedef struct packed {
      logic [3:0] block_id;
      logic [1:0] offset;   // Block index within the image
      logic       init;
   } page_t;

   typedef struct packed {
      slot_typ_e   typ;
      page_t [3:0] page;
   } subslot_t;

   typedef struct packed {
      slot_typ_e      typ;
      subslot_t [3:0] subslot;
   } slot_t;

   typedef slot_t [3:0] slot_map_t;

   typedef struct packed {
      block_typ_e  typ;
      logic [7:0]  block_count;
      logic [24:0] mem_offset;   // SDRAM byte address
   } mem_block_t;

   // Work order for the copier
   typedef struct packed {
      logic [27:0] src_addr;
      logic [7:0]  block_count;
      logic        fill;     // Write FF, no DDR3 reads
      logic        to_kbd;
   } copy_job_t;

   localparam int kbd_layout_bytes = 512;
   localparam logic [7:0] ram_fill_byte = 8'hff;

endpackage

// ==== source/config_sequencer.sv ====
`timescale 1ns/1ps

module config_sequencer #(
   parameter int max_config = 16
) (
   input  logic                                     clk,
   input  logic                                     arst_n,
   input  logic                                     update_request,
   input  logic [1:0]                               msx_type,
   input  msx_upload_pkg::config_t [max_config-1:0] msx_config,
   input  logic                                     ddr3_ready,
   input  logic                                     clear_done,
   input  logic                                     copy_done,
   output logic                                     update_ack,
   output logic                                     busy,
   output logic                                     clear_start,
   output logic                                     fill_valid,
   output msx_upload_pkg::config_t                  fill_entry,
   output msx_upload_pkg::slot_typ_e                fill_slot_typ,
   output logic                                     copy_start,
   output msx_upload_pkg::copy_job_t                copy_job,
   output logic                                     copy_rewind
);

   localparam int cnt_w = (max_config > 1) ? $clog2(max_config) : 1;

   typedef enum logic [2:0] {
      st_idle,
      st_clear,
      st_fill,
      st_copy,
      st_next
   } state_e;

   state_e           state;
   logic [cnt_w-1:0] config_cnt;
   logic             is_mem;   // Entry goes to SDRAM and the map
   logic             is_kbd;

   assign fill_entry = msx_config[config_cnt];

   assign is_mem = fill_entry.typ == msx_upload_pkg::config_ram ||
                   fill_entry.typ == msx_upload_pkg::config_bios ||
                   fill_entry.typ == msx_upload_pkg::config_fdc;
   assign is_kbd = fill_entry.typ == msx_upload_pkg::config_kbd_layout;

   always_comb begin
      case (fill_entry.typ)
         msx_upload_pkg::config_bios,
         msx_upload_pkg::config_fdc: fill_slot_typ = msx_upload_pkg::slot_typ_rom;
         default: begin
            // MSX1 plain RAM, anything newer gets the MSX2 variant
            fill_slot_typ = (msx_type == 2'd0) ? msx_upload_pkg::slot_typ_ram :
                                                 msx_upload_pkg::slot_typ_msx2_ram;
         end
      endcase
   end

   always_comb begin
      copy_job.src_addr    = fill_entry.store_address;
      copy_job.block_count = fill_entry.block_count;
      copy_job.fill        = fill_entry.typ == msx_upload_pkg::config_ram;
      copy_job.to_kbd      = is_kbd;
   end

   // DDR3 must be free before a job is handed over
   assign fill_valid = state == st_fill && is_mem && ddr3_ready;
   assign copy_start = state == st_fill && (is_mem || is_kbd) && ddr3_ready;
   assign busy       = state != st_idle;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state       <= st_idle;
         config_cnt  <= '0;
         update_ack  <= 1'b0;
         clear_start <= 1'b0;
         copy_rewind <= 1'b0;
      end else begin
         clear_start <= 1'b0;
         copy_rewind <= 1'b0;
         case (state)
            st_idle: begin
               update_ack <= update_request;
               if (update_request) begin
                  config_cnt  <= '0;
                  clear_start <= 1'b1;
                  copy_rewind <= 1'b1;   // SDRAM image starts over at 0
                  state       <= st_clear;
               end
            end
            st_clear: begin
               if (clear_done) state <= st_fill;
            end
            st_fill: begin
               if (copy_start) begin
                  state <= st_copy;
               end else if (!is_mem && !is_kbd) begin
                  state <= st_next;   // Unused entry
               end
            end
            st_copy: begin
               if (copy_done) state <= st_next;
            end
            st_next: begin
               if (config_cnt == cnt_w'(max_config - 1)) begin
                  state <= st_idle;
               end else begin
                  config_cnt <= config_cnt + 1'b1;
                  state      <= st_fill;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Empty jobs would leave the copier counting through the whole range
   a_copy_nonempty: assert property (@(posedge clk) disable iff (!arst_n)
      copy_start |-> (copy_job.block_count != 8'd0 || copy_job.to_kbd))
      else $error("copy job started with zero block_count");

endmodule

// ==== source/memory_map.sv ====
`timescale 1ns/1ps

module memory_map #(
   parameter int max_mem_block = 16
) (
   input  logic                                           clk,
   input  logic                                           arst_n,
   input  logic                                           clear_start,
   input  logic                                           fill_valid,
   input  msx_upload_pkg::config_t                        fill_entry,
   input  msx_upload_pkg::slot_typ_e                      fill_slot_typ,
   input  logic [24:0]                                    sdram_addr,
   output logic                                           clear_done,
   output msx_upload_pkg::slot_map_t                      slot_map,
   output msx_upload_pkg::mem_block_t [max_mem_block-1:0] mem_blocks
);

   logic                       clearing;
   logic [5:0]                 clear_idx;   // Slot, subslot, page
   logic [1:0]                 fill_slot;
   logic [1:0]                 fill_sub;
   msx_upload_pkg::block_typ_e fill_block_typ;

   assign fill_slot = fill_entry.slot;
   assign fill_sub  = fill_entry.sub_slot;

   always_comb begin
      case (fill_entry.typ)
         msx_upload_pkg::config_ram: fill_block_typ = msx_upload_pkg::block_typ_ram;
         msx_upload_pkg::config_fdc: fill_block_typ = msx_upload_pkg::block_typ_fdc;
         default:                    fill_block_typ = msx_upload_pkg::block_typ_rom;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         clearing   <= 1'b0;
         clear_idx  <= '0;
         clear_done <= 1'b0;
         slot_map   <= '0;
         mem_blocks <= '0;
      end else begin
         clear_done <= 1'b0;

         if (clear_start) begin
            clearing  <= 1'b1;
            clear_idx <= '0;
         end else if (clearing) begin
            // One page per cycle
            slot_map[clear_idx[5:4]].typ <= msx_upload_pkg::slot_typ_empty;
            slot_map[clear_idx[5:4]].subslot[clear_idx[3:2]].page[clear_idx[1:0]].init <= 1'b0;
            clear_idx <= clear_idx + 6'd1;
            if (&clear_idx) begin
               clearing   <= 1'b0;
               clear_done <= 1'b1;
            end
         end

         if (fill_valid) begin
            if (slot_map[fill_slot].typ == msx_upload_pkg::slot_typ_empty) begin
               slot_map[fill_slot].typ <= fill_slot_typ;
            end
            if (fill_sub != 2'd0) begin
               slot_map[fill_slot].typ <= msx_upload_pkg::slot_typ_mapper;   // Expanded slot
            end
            slot_map[fill_slot].subslot[fill_sub].typ <= fill_slot_typ;

            // Pages from start_block on, as far as the image reaches
            for (int p = 0; p < 4; p++) begin
               if (p >= int'(fill_entry.start_block) &&
                   p - int'(fill_entry.start_block) < int'(fill_entry.block_count)) begin
                  slot_map[fill_slot].subslot[fill_sub].page[p].block_id <= fill_entry.block_id;
                  slot_map[fill_slot].subslot[fill_sub].page[p].offset <=
                     2'(p - int'(fill_entry.start_block));
                  slot_map[fill_slot].subslot[fill_sub].page[p].init <= 1'b1;
               end
            end

            mem_blocks[fill_entry.block_id].typ         <= fill_block_typ;
            mem_blocks[fill_entry.block_id].block_count <= fill_entry.block_count;
            mem_blocks[fill_entry.block_id].mem_offset  <= sdram_addr;
         end
      end
   end

   a_block_id_range: assert property (@(posedge clk) disable iff (!arst_n)
      fill_valid |-> int'(fill_entry.block_id) < max_mem_block)
      else $error("block_id %0d outside the block table", fill_entry.block_id);

endmodule

// ==== source/block_copier.sv ====
`timescale 1ns/1ps

module block_copier #(
   parameter int block_log2 = 14
) (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      copy_start,
   input  msx_upload_pkg::copy_job_t copy_job,
   input  logic                      copy_rewind,
   input  logic                      ddr3_ready,
   input  logic [7:0]                ddr3_dout,
   input  logic                      sdram_ready,
   output logic                      copy_done,
   output logic [27:0]               ddr3_addr,
   output logic                      ddr3_rd,
   output logic [24:0]               sdram_addr,
   output logic [7:0]                sdram_din,
   output logic                      sdram_we,
   output logic [9:0]                kbd_addr,
   output logic [7:0]                kbd_din,
   output logic                      kbd_we
);

   // Wide enough for a full job and for a keyboard layout
   localparam int cnt_w = (8 + block_log2 > 10) ? 8 + block_log2 : 10;

   typedef enum logic [2:0] {
      c_idle,
      c_read,
      c_wait_low,
      c_wait_high,
      c_write
   } state_e;

   state_e                    state;
   msx_upload_pkg::copy_job_t job;
   logic [cnt_w-1:0]          byte_idx;
   logic [cnt_w-1:0]          byte_last;
   logic [7:0]                data_q;
   logic                      write_ok;

   assign ddr3_addr = job.src_addr + 28'(byte_idx);
   assign ddr3_rd   = state == c_read && ddr3_ready;

   // Keyboard RAM never stalls
   assign write_ok = state == c_write && (job.to_kbd || sdram_ready);
   assign sdram_we = write_ok && !job.to_kbd;
   assign kbd_we   = write_ok && job.to_kbd;

   assign sdram_din = data_q;
   assign kbd_din   = data_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= c_idle;
         job        <= '0;
         byte_idx   <= '0;
         byte_last  <= '0;
         sdram_addr <= '0;
         kbd_addr   <= '0;
         copy_done  <= 1'b0;
      end else begin
         copy_done <= 1'b0;
         if (copy_rewind) sdram_addr <= '0;

         case (state)
            c_idle: begin
               if (copy_start) begin
                  job      <= copy_job;
                  byte_idx <= '0;
                  kbd_addr <= '0;
                  if (copy_job.to_kbd) begin
                     byte_last <= cnt_w'(msx_upload_pkg::kbd_layout_bytes - 1);
                  end else begin
                     byte_last <= (cnt_w'(copy_job.block_count) << block_log2) - cnt_w'(1);
                  end
                  state <= copy_job.fill ? c_write : c_read;
               end
            end
            c_read: begin
               if (ddr3_ready) state <= c_wait_low;   // Read pulse this cycle
            end
            c_wait_low: begin
               if (!ddr3_ready) state <= c_wait_high;
            end
            c_wait_high: begin
               if (ddr3_ready) state <= c_write;   // Data latched on this edge
            end
            c_write: begin
               if (write_ok) begin
                  if (job.to_kbd) begin
                     kbd_addr <= kbd_addr + 10'd1;
                  end else begin
                     sdram_addr <= sdram_addr + 25'd1;
                  end
                  byte_idx <= byte_idx + 1'b1;
                  if (byte_idx == byte_last) begin
                     copy_done <= 1'b1;
                     state     <= c_idle;
                  end else if (!job.fill) begin
                     state <= c_read;
                  end
               end
            end
            default: state <= c_idle;
         endcase
      end
   end

   // Byte in flight
   always_ff @(posedge clk) begin
      if (state == c_idle && copy_start) begin
         data_q <= msx_upload_pkg::ram_fill_byte;
      end else if (state == c_wait_high && ddr3_ready) begin
         data_q <= ddr3_dout;
      end
   end

   // Keyboard address and byte index step together
   a_kbd_addr_tracks: assert property (@(posedge clk) disable iff (!arst_n)
      kbd_we |-> cnt_w'(kbd_addr) == byte_idx)
      else $error("kbd_addr out of step with the byte index");

   a_fill_data: assert property (@(posedge clk) disable iff (!arst_n)
      sdram_we && job.fill |-> sdram_din == msx_upload_pkg::ram_fill_byte)
      else $error("RAM fill wrote a byte other than the fill value");

endmodule

// ==== source/upload_ctrl.sv ====
`timescale 1ns/1ps

module upload_ctrl #(
   parameter int max_config    = 16,
   parameter int max_mem_block = 16,
   parameter int block_log2    = 14
) (
   input  logic                                           clk,
   input  logic                                           arst_n,
   input  logic                                           update_request,
   input  logic [1:0]                                     msx_type,
   input  msx_upload_pkg::config_t [max_config-1:0]       msx_config,
   input  logic                                           ddr3_ready,
   input  logic [7:0]                                     ddr3_dout,
   input  logic                                           sdram_ready,
   output logic                                           update_ack,
   output logic                                           mem_request,
   output logic [27:0]                                    ddr3_addr,
   output logic                                           ddr3_rd,
   output logic [24:0]                                    sdram_addr,
   output logic [7:0]                                     sdram_din,
   output logic                                           sdram_we,
   output logic [9:0]                                     kbd_addr,
   output logic [7:0]                                     kbd_din,
   output logic                                           kbd_we,
   output msx_upload_pkg::slot_map_t                      slot_map,
   output msx_upload_pkg::mem_block_t [max_mem_block-1:0] mem_blocks
);

   logic                      busy;
   logic                      clear_start;
   logic                      clear_done;
   logic                      fill_valid;
   msx_upload_pkg::config_t   fill_entry;
   msx_upload_pkg::slot_typ_e fill_slot_typ;
   logic                      copy_start;
   msx_upload_pkg::copy_job_t copy_job;
   logic                      copy_done;
   logic                      copy_rewind;

   assign mem_request = busy;   // Memories owned for the whole upload

   config_sequencer #(
      .max_config(max_config)
   ) config_sequencer_i (
      .clk           (clk),
      .arst_n        (arst_n),
      .update_request(update_request),
      .msx_type      (msx_type),
      .msx_config    (msx_config),
      .ddr3_ready    (ddr3_ready),
      .clear_done    (clear_done),
      .copy_done     (copy_done),
      .update_ack    (update_ack),
      .busy          (busy),
      .clear_start   (clear_start),
      .fill_valid    (fill_valid),
      .fill_entry    (fill_entry),
      .fill_slot_typ (fill_slot_typ),
      .copy_start    (copy_start),
      .copy_job      (copy_job),
      .copy_rewind   (copy_rewind)
   );

   memory_map #(
      .max_mem_block(max_mem_block)
   ) memory_map_i (
      .clk          (clk),
      .arst_n       (arst_n),
      .clear_start  (clear_start),
      .fill_valid   (fill_valid),
      .fill_entry   (fill_entry),
      .fill_slot_typ(fill_slot_typ),
      .sdram_addr   (sdram_addr),
      .clear_done   (clear_done),
      .slot_map     (slot_map),
      .mem_blocks   (mem_blocks)
   );

   block_copier #(
      .block_log2(block_log2)
   ) block_copier_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .copy_start (copy_start),
      .copy_job   (copy_job),
      .copy_rewind(copy_rewind),
      .ddr3_ready (ddr3_ready),
      .ddr3_dout  (ddr3_dout),
      .sdram_ready(sdram_ready),
      .copy_done  (copy_done),
      .ddr3_addr  (ddr3_addr),
      .ddr3_rd    (ddr3_rd),
      .sdram_addr (sdram_addr),
      .sdram_din  (sdram_din),
      .sdram_we   (sdram_we),
      .kbd_addr   (kbd_addr),
      .kbd_din    (kbd_din),
      .kbd_we     (kbd_we)
   );

endmodule

// ==== sim/upload_ctrl_tb.sv ====
`timescale 1ns/1ps

module upload_ctrl_tb;

   localparam int n_cfg     = 4;
   localparam int n_blk     = 16;
   localparam int blk_log2  = 4;
   localparam int blk_bytes = 1 << blk_log2;

   logic                                   clk;
   logic                                   arst_n;
   logic                                   update_request;
   logic [1:0]                             msx_type;
   msx_upload_pkg::config_t [n_cfg-1:0]    msx_config;
   logic                                   ddr3_ready;
   logic [7:0]                             ddr3_dout;
   logic                                   sdram_ready;
   logic                                   update_ack;
   logic                                   mem_request;
   logic [27:0]                            ddr3_addr;
   logic                                   ddr3_rd;
   logic [24:0]                            sdram_addr;
   logic [7:0]                             sdram_din;
   logic                                   sdram_we;
   logic [9:0]                             kbd_addr;
   logic [7:0]                             kbd_din;
   logic                                   kbd_we;
   msx_upload_pkg::slot_map_t              slot_map;
   msx_upload_pkg::mem_block_t [n_blk-1:0] mem_blocks;

   msx_upload_pkg::config_t [n_cfg-1:0] test_cfg;
   logic [1:0]                          test_type;
   msx_upload_pkg::page_t               exp_page [4][4][4];
   string                               lines[$];
   bit                                  exp_kbd[$];
   int                                  exp_addr[$];
   logic [7:0]                          exp_data[$];
   int                                  errors = 0;
   int                                  cycle = 0;
   int                                  cycle_limit = 0;
   int                                  rd_count = 0;
   int                                  exp_rd = 0;

   upload_ctrl #(
      .max_config   (n_cfg),
      .max_mem_block(n_blk),
      .block_log2   (blk_log2)
   ) upload_ctrl_i (
      .clk           (clk),
      .arst_n        (arst_n),
      .update_request(update_request),
      .msx_type      (msx_type),
      .msx_config    (msx_config),
      .ddr3_ready    (ddr3_ready),
      .ddr3_dout     (ddr3_dout),
      .sdram_ready   (sdram_ready),
      .update_ack    (update_ack),
      .mem_request   (mem_request),
      .ddr3_addr     (ddr3_addr),
      .ddr3_rd       (ddr3_rd),
      .sdram_addr    (sdram_addr),
      .sdram_din     (sdram_din),
      .sdram_we      (sdram_we),
      .kbd_addr      (kbd_addr),
      .kbd_din       (kbd_din),
      .kbd_we        (kbd_we),
      .slot_map      (slot_map),
      .mem_blocks    (mem_blocks)
   );

   // DDR3 content model
   function automatic logic [7:0] ddr3_byte(input logic [27:0] addr);
      return addr[7:0] ^ addr[15:8];
   endfunction

   function automatic int entry_bytes(input msx_upload_pkg::config_t c);
      case (c.typ)
         msx_upload_pkg::config_ram,
         msx_upload_pkg::config_bios,
         msx_upload_pkg::config_fdc:        return int'(c.block_count) * blk_bytes;
         msx_upload_pkg::config_kbd_layout: return msx_upload_pkg::kbd_layout_bytes;
         default:                           return 0;
      endcase
   endfunction

   function automatic msx_upload_pkg::config_t parse_cfg(input string line);
      msx_upload_pkg::config_t c;
      string                   kw;
      int                      typ, slot, sub, start, id, count;
      logic [27:0]             addr;
      void'($sscanf(line, "%s %d %d %d %d %d %d %h", kw, typ, slot, sub, start, id, count,
                    addr));
      c.typ           = msx_upload_pkg::config_typ_e'(typ);
      c.slot          = 2'(slot);
      c.sub_slot      = 2'(sub);
      c.start_block   = 2'(start);
      c.block_id      = 4'(id);
      c.block_count   = 8'(count);
      c.store_address = addr;
      return c;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic expect_write(input bit to_kbd, input int addr, input logic [7:0] data);
      exp_kbd.push_back(to_kbd);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   // Pages covered by an image, capped at page 3
   task automatic mark_pages(input msx_upload_pkg::config_t c);
      for (int p = int'(c.start_block);
           p < 4 && p - int'(c.start_block) < int'(c.block_count); p++) begin
         exp_page[c.slot][c.sub_slot][p].block_id = c.block_id;
         exp_page[c.slot][c.sub_slot][p].offset   = 2'(p - int'(c.start_block));
         exp_page[c.slot][c.sub_slot][p].init     = 1'b1;
      end
   endtask

   task automatic build_expectations();
      int ptr;
      int n;
      ptr    = 0;
      exp_rd = 0;
      exp_kbd.delete();
      exp_addr.delete();
      exp_data.delete();
      for (int s = 0; s < 4; s++)
         for (int ss = 0; ss < 4; ss++)
            for (int p = 0; p < 4; p++)
               exp_page[s][ss][p] = '0;   // Clear drops every init
      for (int e = 0; e < n_cfg; e++) begin
         n = entry_bytes(test_cfg[e]);
         case (test_cfg[e].typ)
            msx_upload_pkg::config_ram: begin
               for (int i = 0; i < n; i++) expect_write(1'b0, ptr + i, 8'hff);
            end
            msx_upload_pkg::config_bios,
            msx_upload_pkg::config_fdc: begin
               for (int i = 0; i < n; i++)
                  expect_write(1'b0, ptr + i, ddr3_byte(test_cfg[e].store_address + 28'(i)));
               exp_rd += n;
            end
            msx_upload_pkg::config_kbd_layout: begin
               for (int i = 0; i < n; i++)
                  expect_write(1'b1, i, ddr3_byte(test_cfg[e].store_address + 28'(i)));
               exp_rd += n;
            end
            default: ;
         endcase
         if (test_cfg[e].typ inside {msx_upload_pkg::config_ram, msx_upload_pkg::config_bios,
                                     msx_upload_pkg::config_fdc}) begin
            mark_pages(test_cfg[e]);
            ptr += n;
         end
      end
   endtask

   task automatic check_write();
      bit         to_kbd;
      int         addr;
      logic [7:0] data;
      assert (exp_addr.size() > 0) else begin
         $display("Write strobe seen when no write was expected");
         errors++;
      end
      if (exp_addr.size() > 0) begin
         to_kbd = exp_kbd.pop_front();
         addr   = exp_addr.pop_front();
         data   = exp_data.pop_front();
         assert (kbd_we == to_kbd) else begin
            $display("Write went to the wrong memory at expected address %0d", addr);
            errors++;
         end
         if (to_kbd) begin
            check_value("kbd_addr", kbd_addr, addr);
            check_value("kbd_din", kbd_din, data);
         end else begin
            check_value("sdram_addr", sdram_addr, addr);
            check_value("sdram_din", sdram_din, data);
         end
      end
   endtask

   task automatic run_update();
      int tail;
      tail = 0;
      build_expectations();
      @(posedge clk);
      #1;
      msx_config     = test_cfg;
      msx_type       = test_type;
      rd_count       = 0;
      update_request = 1'b1;
      @(negedge clk);
      check_value("update_ack", update_ack, 1'b0);   // Not in the same cycle
      while (!update_ack) @(negedge clk);
      check_value("mem_request", mem_request, 1'b1);
      @(posedge clk);
      #1 update_request = 1'b0;
      while (update_ack) begin
         @(negedge clk);
         if (update_ack && !mem_request) tail++;
      end
      // Busy drops one cycle before the acknowledge
      assert (tail == 1) else begin
         $display("mem_request dropped early, %0d cycles before update_ack fell", tail);
         errors++;
      end
      assert (exp_addr.size() == 0) else begin
         $display("Upload ended with %0d writes still missing", exp_addr.size());
         errors++;
      end
      check_value("ddr3_rd count", rd_count, exp_rd);
   endtask

   task automatic check_pages();
      msx_upload_pkg::page_t pg;
      for (int s = 0; s < 4; s++)
         for (int ss = 0; ss < 4; ss++)
            for (int p = 0; p < 4; p++) begin
               pg = slot_map[s].subslot[ss].page[p];
               check_value($sformatf("slot_map[%0d][%0d][%0d].init", s, ss, p), pg.init,
                           exp_page[s][ss][p].init);
               if (exp_page[s][ss][p].init) begin
                  check_value($sformatf("slot_map[%0d][%0d][%0d].block_id", s, ss, p),
                              pg.block_id, exp_page[s][ss][p].block_id);
                  check_value($sformatf("slot_map[%0d][%0d][%0d].offset", s, ss, p),
                              pg.offset, exp_page[s][ss][p].offset);
               end
            end
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle++;
      if (cycle_limit > 0 && cycle > cycle_limit) begin
         $display("Timeout after %0d cycles, an upload never finished", cycle);
         $display("Verification failed");
         $finish;
      end
   end

   // DDR3 and SDRAM responders share one random stream
   initial begin : responders
      int          ddr3_wait;
      bit          rd_pending;
      logic [27:0] rd_addr;
      ddr3_wait   = 0;
      rd_addr     = '0;
      ddr3_ready  = 1'b1;
      ddr3_dout   = '0;
      sdram_ready = 1'b1;
      void'($urandom(76));
      forever begin
         @(negedge clk);
         rd_pending = ddr3_rd;
         if (ddr3_rd) rd_addr = ddr3_addr;
         @(posedge clk);
         #1;
         sdram_ready = ($urandom % 4) != 0;
         if (ddr3_wait > 0) begin
            ddr3_wait--;
            if (ddr3_wait == 0) begin
               ddr3_dout  = ddr3_byte(rd_addr);
               ddr3_ready = 1'b1;
            end
         end else if (rd_pending) begin
            ddr3_ready = 1'b0;
            ddr3_wait  = 1 + $urandom % 4;
         end
      end
   end

   always @(negedge clk) begin
      if (ddr3_rd) rd_count++;
      if (sdram_we || kbd_we) check_write();
   end

   initial begin : main
      int    fd, idx, ncfg, ntests, npass, err_start, total_bytes;
      int    v0, v1, v2, v3;
      string line, kw, name;
      logic [24:0] offset;
      update_request = 1'b0;
      msx_type       = '0;
      msx_config     = '0;
      arst_n         = 1'b0;
      ncfg           = 0;
      ntests         = 0;
      npass          = 0;
      err_start      = 0;
      total_bytes    = 0;

      fd = $fopen("sim/upload_tests.txt", "r");
      assert (fd != 0) else begin
         $display("Could not open sim/upload_tests.txt");
         errors++;
      end
      if (fd != 0) begin
         while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#")
               lines.push_back(line);
         end
         $fclose(fd);
      end
      foreach (lines[i]) begin
         void'($sscanf(lines[i], "%s", kw));
         if (kw == "cfg") total_bytes += entry_bytes(parse_cfg(lines[i]));
         if (kw == "test") ntests++;
      end
      cycle_limit = 8 * total_bytes + 200 * ntests + 20;
      ntests = 0;

      repeat (7) @(posedge clk);
      @(negedge clk);
      check_value("update_ack", update_ack, 1'b0);
      check_value("mem_request", mem_request, 1'b0);
      check_value("ddr3_rd", ddr3_rd, 1'b0);
      check_value("sdram_we", sdram_we, 1'b0);
      check_value("kbd_we", kbd_we, 1'b0);
      for (int s = 0; s < 4; s++)
         check_value($sformatf("slot_map[%0d].typ", s), slot_map[s].typ, 0);
      @(posedge clk);
      #1 arst_n = 1'b1;

      for (idx = 0; idx < lines.size(); idx++) begin
         void'($sscanf(lines[idx], "%s", kw));
         if (kw == "test") begin
            void'($sscanf(lines[idx], "%s %s %d", kw, name, v0));
            test_type = 2'(v0);
            test_cfg  = '0;
            ncfg      = 0;
            err_start = errors;
         end else if (kw == "cfg" && ncfg < n_cfg) begin
            test_cfg[ncfg] = parse_cfg(lines[idx]);
            ncfg++;
         end else if (kw == "run") begin
            run_update();
            check_pages();
         end else if (kw == "slots") begin
            void'($sscanf(lines[idx], "%s %d %d %d %d", kw, v0, v1, v2, v3));
            check_value("slot_map[0].typ", slot_map[0].typ, v0);
            check_value("slot_map[1].typ", slot_map[1].typ, v1);
            check_value("slot_map[2].typ", slot_map[2].typ, v2);
            check_value("slot_map[3].typ", slot_map[3].typ, v3);
         end else if (kw == "sub") begin
            void'($sscanf(lines[idx], "%s %d %d %d", kw, v0, v1, v2));
            check_value($sformatf("slot_map[%0d].subslot[%0d].typ", v0, v1),
                        slot_map[v0].subslot[v1].typ, v2);
         end else if (kw == "blk") begin
            void'($sscanf(lines[idx], "%s %d %d %d %h", kw, v0, v1, v2, offset));
            check_value($sformatf("mem_blocks[%0d].typ", v0), mem_blocks[v0].typ, v1);
            check_value($sformatf("mem_blocks[%0d].block_count", v0),
                        mem_blocks[v0].block_count, v2);
            check_value($sformatf("mem_blocks[%0d].mem_offset", v0),
                        mem_blocks[v0].mem_offset, offset);
         end else if (kw == "end") begin
            ntests++;
            if (errors == err_start) npass++;
            $display("%s test %s, %0d errors", (errors == err_start) ? "PASS" : "FAIL",
                     name, errors - err_start);
         end
      end

      $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", ntests, npass,
               ntests - npass, errors);
      if (errors == 0 && ntests > 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== sim/upload_tests.txt ====
# test <name> <msx_type> / cfg <typ> <slot> <sub> <start_block> <block_id> <count> <addr hex>
# expected after run: slots <t0..t3> / sub <slot> <sub> <typ> / blk <id> <typ> <count> <offset>
test msx1_basic 0
cfg 2 0 0 0 0 2 0001000
cfg 1 3 0 0 1 4 0000000
cfg 4 0 0 0 0 0 0002000
cfg 0 0 0 0 0 0 0000000
run
slots 1 0 0 2
sub 0 0 1
sub 3 0 2
blk 0 1 2 0000000
blk 1 0 4 0000020
end
test msx2_mapper 1
cfg 1 3 2 0 2 3 0000000
cfg 3 2 0 1 3 1 00123f8
cfg 2 0 0 2 4 3 0004000
cfg 0 0 0 0 0 0 0000000
run
slots 1 0 1 4
sub 3 2 3
sub 2 0 1
sub 0 0 1
blk 2 0 3 0000000
blk 3 2 1 0000030
blk 4 1 3 0000040
end
test kbd_and_gaps 2
cfg 0 0 0 0 0 0 0000000
cfg 4 0 0 0 0 0 0007f00
cfg 2 1 1 3 15 1 0000000
cfg 1 1 1 0 5 2 0000000
run
slots 0 4 0 0
sub 1 1 3
blk 15 1 1 0000000
blk 5 0 2 0000010
end

// ==== filelist.f ====
source/msx_upload_pkg.sv
source/config_sequencer.sv
source/memory_map.sv
source/block_copier.sv
source/upload_ctrl.sv
sim/upload_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: msx_upload

sources:
  - source/msx_upload_pkg.sv
  - source/config_sequencer.sv
  - source/memory_map.sv
  - source/block_copier.sv
  - source/upload_ctrl.sv
  - target: simulation
    files:
      - sim/upload_ctrl_tb.sv
